// ==== design/caddr_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build constants for the keyboard and status corner, counts in clk50 cycles
// CADDR_KB_DEPTH must be a power of two and at least 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CADDR_CONSTS_SVH
`define CADDR_CONSTS_SVH

// equal consecutive samples before the filtered ps2 clock may change
`define CADDR_PS2_FILTER 4

// event queue entries
`define CADDR_KB_DEPTH 4

// steady pressed cycles before the switch counts as a press
`define CADDR_DEBOUNCE 64

// cycles the system reset is held once triggered
`define CADDR_RESET_STRETCH 16

// scan set 2 prefix bytes
`define CADDR_PREFIX_RELEASE 8'hf0
`define CADDR_PREFIX_EXTENDED 8'he0

`endif

// ==== design/caddr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types shared by the keyboard path, kb_event_t is the word the cpu reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package caddr_pkg;

   // one received ps2 frame
   typedef struct packed {
      logic [7:0] data;
      logic       frame_ok;   // start 0, stop 1, odd parity
   } ps2_frame_t;

   // key event, released on top
   typedef struct packed {
      logic       released;
      logic       extended;
      logic [7:0] code;
   } kb_event_t;

   typedef enum logic [1:0] {
      rx_idle,
      rx_shifting,
      rx_check
   } ps2_rx_state_e;

   typedef enum logic [1:0] {
      dec_base,
      dec_got_extended,
      dec_got_release
   } kb_dec_state_e;

endpackage

`default_nettype wire

// ==== design/reset_support.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// switch is active high; one press per hold, release rearms it
// sys_rst follows rst_n one cycle late and stays up for the stretch count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "caddr_consts.svh"

module reset_support (
   input  logic clk50,
   input  logic rst_n,
   input  logic switch,
   output logic sys_rst
);

   localparam int deb_w = $clog2(`CADDR_DEBOUNCE + 1);
   localparam int str_w = $clog2(`CADDR_RESET_STRETCH + 1);

   logic [1:0]       sw_sync;
   logic [deb_w-1:0] deb_cnt;
   logic             fired;         // press already taken for this hold
   logic             press;
   logic [str_w-1:0] stretch_cnt;

   assign press = sw_sync[1] && !fired && (deb_cnt == deb_w'(`CADDR_DEBOUNCE - 1));

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         sw_sync <= 2'b00;
         deb_cnt <= '0;
         fired   <= 1'b0;
      end else begin
         sw_sync <= {sw_sync[0], switch};
         if (!sw_sync[1]) begin
            deb_cnt <= '0;            // bounce or release restarts the count
            fired   <= 1'b0;
         end else if (press) begin
            fired <= 1'b1;
         end else if (!fired) begin
            deb_cnt <= deb_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (!rst_n || press) begin
         stretch_cnt <= str_w'(`CADDR_RESET_STRETCH);
      end else if (stretch_cnt != '0) begin
         stretch_cnt <= stretch_cnt - 1'b1;
      end
   end

   assign sys_rst = (stretch_cnt != '0);

   // board reset must always reach the system reset
   a_rst_n_to_sys_rst : assert property (@(posedge clk50) !rst_n |=> sys_rst);

endmodule

`default_nettype wire

// ==== design/ps2_receiver.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keyboard to host frames only, no line drive and no frame timeout
// a stray falling edge misaligns the frame until its check fails
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "caddr_consts.svh"

module ps2_receiver (
   input  logic                  clk50,
   input  logic                  sys_rst,
   input  logic                  ps2_clk,
   input  logic                  ps2_data,
   output caddr_pkg::ps2_frame_t frame,
   output logic                  frame_valid
);

   import caddr_pkg::*;

   localparam int filt_n = `CADDR_PS2_FILTER;

   logic [1:0]        clk_sync;
   logic [1:0]        dat_sync;
   logic [filt_n-1:0] filt_sr;
   logic              clk_f;        // filtered ps2 clock
   logic              fall_edge;
   ps2_rx_state_e     state;
   logic [3:0]        bit_cnt;
   logic              start_q;
   logic [9:0]        shift_q;      // parity and stop land on top

   always_ff @(posedge clk50) begin
      if (sys_rst) begin
         clk_sync <= 2'b11;
         dat_sync <= 2'b11;
         filt_sr  <= '1;
         clk_f    <= 1'b1;
      end else begin
         clk_sync <= {clk_sync[0], ps2_clk};
         dat_sync <= {dat_sync[0], ps2_data};
         filt_sr  <= {filt_sr[filt_n-2:0], clk_sync[1]};
         if (filt_sr == '1) begin
            clk_f <= 1'b1;
         end else if (filt_sr == '0) begin
            clk_f <= 1'b0;
         end
      end
   end

   // high for the one cycle before clk_f drops
   assign fall_edge = clk_f && (filt_sr == '0);

   always_ff @(posedge clk50) begin
      if (sys_rst) begin
         state   <= rx_idle;
         bit_cnt <= '0;
      end else begin
         case (state)
            rx_idle: begin
               if (fall_edge) begin
                  state   <= rx_shifting;
                  bit_cnt <= '0;
               end
            end
            rx_shifting: begin
               if (fall_edge) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 4'd9) begin
                     state <= rx_check;   // stop bit taken
                  end
               end
            end
            rx_check: state <= rx_idle;
            default:  state <= rx_idle;
         endcase
      end
   end

   always_ff @(posedge clk50) begin
      if (fall_edge) begin
         if (state == rx_idle) begin
            start_q <= dat_sync[1];
         end else if (state == rx_shifting) begin
            shift_q <= {dat_sync[1], shift_q[9:1]};   // lsb first
         end
      end
   end

   assign frame_valid    = (state == rx_check);
   assign frame.data     = shift_q[7:0];
   assign frame.frame_ok = !start_q && shift_q[9] && (^shift_q[8:0]);

   a_valid_single : assert property (@(posedge clk50) disable iff (sys_rst)
      frame_valid |=> !frame_valid);

endmodule

`default_nettype wire

// ==== design/kb_scan_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scan set 2 prefixes only, no typematic or pause key handling
// frame_err is sticky until sys_rst
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "caddr_consts.svh"

module kb_scan_decoder (
   input  logic                  clk50,
   input  logic                  sys_rst,
   input  caddr_pkg::ps2_frame_t frame,
   input  logic                  frame_valid,
   output caddr_pkg::kb_event_t  kb_event,
   output logic                  event_valid,
   output logic                  frame_err
);

   import caddr_pkg::*;

   kb_dec_state_e state;
   logic          ext_q;         // E0 seen, survives a following F0
   logic          is_prefix;

   assign is_prefix = (frame.data == `CADDR_PREFIX_EXTENDED) ||
                      (frame.data == `CADDR_PREFIX_RELEASE);

   always_ff @(posedge clk50) begin
      if (sys_rst) begin
         state       <= dec_base;
         ext_q       <= 1'b0;
         event_valid <= 1'b0;
         frame_err   <= 1'b0;
      end else begin
         event_valid <= 1'b0;
         if (frame_valid) begin
            if (!frame.frame_ok) begin
               frame_err <= 1'b1;
               state     <= dec_base;   // drop pending prefix
               ext_q     <= 1'b0;
            end else if (frame.data == `CADDR_PREFIX_EXTENDED) begin
               state <= dec_got_extended;
               ext_q <= 1'b1;
            end else if (frame.data == `CADDR_PREFIX_RELEASE) begin
               state <= dec_got_release;
            end else begin
               event_valid <= 1'b1;
               state       <= dec_base;
               ext_q       <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (frame_valid && frame.frame_ok && !is_prefix) begin
         kb_event.released <= (state == dec_got_release);
         kb_event.extended <= ext_q;
         kb_event.code     <= frame.data;
      end
   end

endmodule

`default_nettype wire

// ==== design/kb_host_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fall-through queue, kb_data is valid only while kb_ready is high
// an event arriving on a full queue is lost even with a kb_ack that cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "caddr_consts.svh"

module kb_host_port (
   input  logic                 clk50,
   input  logic                 sys_rst,
   input  caddr_pkg::kb_event_t kb_event,
   input  logic                 event_valid,
   input  logic                 kb_ack,
   output caddr_pkg::kb_event_t kb_data,
   output logic                 kb_ready,
   output logic                 overflow
);

   import caddr_pkg::*;

   localparam int depth = `CADDR_KB_DEPTH;
   localparam int ptr_w = $clog2(depth);

   kb_event_t        mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             full;
   logic             push;
   logic             pop;

   assign full = (count == (ptr_w + 1)'(depth));
   assign push = event_valid && !full;
   assign pop  = kb_ack && (count != '0);   // ack on empty is ignored

   always_ff @(posedge clk50) begin
      if (sys_rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (event_valid && full) begin
            overflow <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (push) begin
         mem[wr_ptr] <= kb_event;
      end
   end

   assign kb_data  = mem[rd_ptr];
   assign kb_ready = (count != '0);

   a_count_bound : assert property (@(posedge clk50) disable iff (sys_rst)
      count <= (ptr_w + 1)'(depth));

endmodule

`default_nettype wire

// ==== design/caddr_io_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keyboard and status corner of the board top, single clk50 domain
// led: 0 sys_rst, 1 kb_ready, 2 overflow, 3 frame_err
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module caddr_io_top (
   input  logic                 clk50,
   input  logic                 rst_n,
   input  logic                 switch,
   input  logic                 ps2_clk,
   input  logic                 ps2_data,
   input  logic                 kb_ack,
   output caddr_pkg::kb_event_t kb_data,
   output logic                 kb_ready,
   output logic [3:0]           led
);

   import caddr_pkg::*;

   logic       sys_rst;
   ps2_frame_t frame;
   logic       frame_valid;
   kb_event_t  kb_event;
   logic       event_valid;
   logic       frame_err;
   logic       overflow;

   reset_support i_reset_support (
      .clk50   (clk50),
      .rst_n   (rst_n),
      .switch  (switch),
      .sys_rst (sys_rst)
   );

   ps2_receiver i_ps2_receiver (
      .clk50       (clk50),
      .sys_rst     (sys_rst),
      .ps2_clk     (ps2_clk),
      .ps2_data    (ps2_data),
      .frame       (frame),
      .frame_valid (frame_valid)
   );

   kb_scan_decoder i_kb_scan_decoder (
      .clk50       (clk50),
      .sys_rst     (sys_rst),
      .frame       (frame),
      .frame_valid (frame_valid),
      .kb_event    (kb_event),
      .event_valid (event_valid),
      .frame_err   (frame_err)
   );

   kb_host_port i_kb_host_port (
      .clk50       (clk50),
      .sys_rst     (sys_rst),
      .kb_event    (kb_event),
      .event_valid (event_valid),
      .kb_ack      (kb_ack),
      .kb_data     (kb_data),
      .kb_ready    (kb_ready),
      .overflow    (overflow)
   );

   assign led = {frame_err, overflow, kb_ready, sys_rst};

endmodule

`default_nettype wire

// ==== testbench/tb_caddr_io_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-checking testbench for caddr_io_top, ps2 frames come from a table
// ps2 half period is 20 clk50 cycles, the run stops after 20000 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps
`include "caddr_consts.svh"

module tb_caddr_io_top;

   import caddr_pkg::*;

   localparam int half_period = 20;      // ps2 half period in clk50 cycles
   localparam int max_cycles  = 20000;   // about 30 frames of 450 cycles, switch and margin
   localparam int n_rows      = 15;

   typedef struct packed {
      logic [7:0] data;
      logic       bad_par;
      logic       has_event;
      logic       ack_after;
      kb_event_t  expected;
   } stim_row_t;

   // byte, bad parity, event expected, ack after, expected word
   localparam stim_row_t rows [n_rows] = '{
      '{8'h1c, 1'b0, 1'b1, 1'b1, '{1'b0, 1'b0, 8'h1c}},   // plain make code
      '{8'hf0, 1'b0, 1'b0, 1'b0, '{1'b0, 1'b0, 8'h00}},
      '{8'h1c, 1'b0, 1'b1, 1'b1, '{1'b1, 1'b0, 8'h1c}},   // break code
      '{8'he0, 1'b0, 1'b0, 1'b0, '{1'b0, 1'b0, 8'h00}},
      '{8'hf0, 1'b0, 1'b0, 1'b0, '{1'b0, 1'b0, 8'h00}},
      '{8'h75, 1'b0, 1'b1, 1'b1, '{1'b1, 1'b1, 8'h75}},   // extended break
      '{8'hf0, 1'b0, 1'b0, 1'b0, '{1'b0, 1'b0, 8'h00}},
      '{8'h1c, 1'b1, 1'b0, 1'b0, '{1'b0, 1'b0, 8'h00}},   // bad parity drops the F0
      '{8'h1b, 1'b0, 1'b1, 1'b1, '{1'b0, 1'b0, 8'h1b}},
      '{8'h15, 1'b0, 1'b1, 1'b0, '{1'b0, 1'b0, 8'h15}},
      '{8'h1d, 1'b0, 1'b1, 1'b0, '{1'b0, 1'b0, 8'h1d}},
      '{8'h24, 1'b0, 1'b1, 1'b0, '{1'b0, 1'b0, 8'h24}},
      '{8'h2d, 1'b0, 1'b1, 1'b0, '{1'b0, 1'b0, 8'h2d}},
      '{8'h2c, 1'b0, 1'b1, 1'b1, '{1'b0, 1'b0, 8'h2c}},   // queue full, lost
      '{8'h3c, 1'b0, 1'b1, 1'b0, '{1'b0, 1'b0, 8'h3c}}    // left pending for the switch
   };

   localparam stim_row_t after_reset_row = '{8'h1c, 1'b0, 1'b1, 1'b1, '{1'b0, 1'b0, 8'h1c}};

   logic       clk50;
   logic       rst_n;
   logic       switch;
   logic       ps2_clk;
   logic       ps2_data;
   logic       kb_ack;
   kb_event_t  kb_data;
   logic       kb_ready;
   logic [3:0] led;

   kb_event_t  model_q [$];   // words the cpu should see, oldest first
   logic       model_ovf;
   logic       model_err;
   int         cycle_count;
   int         waited;        // cycles spent in the last sys_rst wait

   caddr_io_top i_caddr_io_top (
      .clk50    (clk50),
      .rst_n    (rst_n),
      .switch   (switch),
      .ps2_clk  (ps2_clk),
      .ps2_data (ps2_data),
      .kb_ack   (kb_ack),
      .kb_data  (kb_data),
      .kb_ready (kb_ready),
      .led      (led)
   );

   initial begin
      clk50 = 1'b0;
      forever #5 clk50 = ~clk50;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_event(input string name, input kb_event_t actual,
                              input kb_event_t expected);
      if (actual !== expected) begin
         $display("Error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
         abort_run("kb_event_t mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("Error at %0t ns: %s expected %b actual %b", $time, name, expected, actual);
         abort_run("status bit mismatch");
      end
   endtask

   task automatic check_cycles(input string name, input int actual, input int expected);
      if (actual != expected) begin
         $display("Error at %0t ns: %s expected %0d actual %0d", $time, name, expected, actual);
         abort_run("cycle count mismatch");
      end
   endtask

   // leaves the caller 1 ns after a rising edge
   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk50);
         #1;
      end
   endtask

   task automatic wait_for_sys_rst(input logic level, output int cycles);
      cycles = 0;
      do begin
         wait_cycles(1);
         cycles++;
      end while (led[0] !== level);
   endtask

   task automatic send_frame(input logic [7:0] data, input logic bad_par);
      logic [10:0] bits;
      int          used;
      int          i;
      bits = {1'b1, (~^data) ^ bad_par, data, 1'b0};   // stop, odd parity, data, start
      used = 0;
      for (i = 0; i < 11; i++) begin
         ps2_data = bits[i];
         wait_cycles(half_period);
         ps2_clk = 1'b0;
         if (i == 10) begin
            do begin
               wait_cycles(1);
               used++;
            end while (i_caddr_io_top.frame_valid !== 1'b1);
            wait_cycles(2);   // event one cycle later, queue one more
            used += 2;
         end
         if (used < half_period) begin
            wait_cycles(half_period - used);
         end
         ps2_clk = 1'b1;
      end
      ps2_data = 1'b1;
      wait_cycles(half_period);   // idle line between frames
   endtask

   task automatic check_status();
      check_bit("led[0]", led[0], 1'b0);
      check_bit("kb_ready", kb_ready, model_q.size() != 0);
      check_bit("led[1]", led[1], model_q.size() != 0);
      check_bit("led[2]", led[2], model_ovf);
      check_bit("led[3]", led[3], model_err);
      if (model_q.size() != 0) begin
         check_event("kb_data", kb_data, model_q[0]);
      end
   endtask

   task automatic drain_queue();
      while (model_q.size() > 0) begin
         check_bit("kb_ready", kb_ready, 1'b1);
         check_event("kb_data", kb_data, model_q.pop_front());
         kb_ack = 1'b1;
         wait_cycles(1);
         kb_ack = 1'b0;
      end
      check_bit("kb_ready", kb_ready, 1'b0);
      kb_ack = 1'b1;   // ack on an empty queue must be ignored
      wait_cycles(1);
      kb_ack = 1'b0;
      check_bit("kb_ready", kb_ready, 1'b0);
      check_bit("led[1]", led[1], 1'b0);
   endtask

   task automatic apply_row(input stim_row_t row);
      send_frame(row.data, row.bad_par);
      if (row.bad_par) begin
         model_err = 1'b1;
      end
      if (row.has_event) begin
         if (model_q.size() < `CADDR_KB_DEPTH) begin
            model_q.push_back(row.expected);
         end else begin
            model_ovf = 1'b1;
         end
      end
      check_status();
      if (row.ack_after) begin
         drain_queue();
      end
   endtask

   initial begin
      cycle_count = 0;
      forever begin
         @(posedge clk50);
         cycle_count++;
         if (cycle_count >= max_cycles) begin
            abort_run($sformatf("timeout after %0d clk50 cycles, the DUT did not respond",
                                cycle_count));
         end
      end
   end

   initial begin
      rst_n     = 1'b0;
      switch    = 1'b0;
      ps2_clk   = 1'b1;
      ps2_data  = 1'b1;
      kb_ack    = 1'b0;
      model_ovf = 1'b0;
      model_err = 1'b0;
      wait_cycles(10);
      rst_n = 1'b1;
      wait_for_sys_rst(1'b0, waited);   // stretch runs out after rst_n
      check_cycles("sys_rst after rst_n", waited, `CADDR_RESET_STRETCH);
      check_status();

      for (int r = 0; r < n_rows; r++) begin
         apply_row(rows[r]);
      end

      switch = 1'b1;
      wait_for_sys_rst(1'b1, waited);
      if (waited < `CADDR_DEBOUNCE || waited > `CADDR_DEBOUNCE + 3) begin
         abort_run($sformatf("Error at %0t ns: switch debounce expected %0d to %0d actual %0d",
                             $time, `CADDR_DEBOUNCE, `CADDR_DEBOUNCE + 3, waited));
      end
      wait_cycles(1);           // queue clears on the first sys_rst edge
      check_bit("led[0]", led[0], 1'b1);
      check_bit("kb_ready", kb_ready, 1'b0);
      check_bit("led[1]", led[1], 1'b0);
      switch = 1'b0;
      model_q.delete();
      model_ovf = 1'b0;
      model_err = 1'b0;
      wait_for_sys_rst(1'b0, waited);
      check_cycles("sys_rst after switch", waited + 1, `CADDR_RESET_STRETCH);
      check_status();
      apply_row(after_reset_row);

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/caddr_pkg.sv
design/reset_support.sv
design/ps2_receiver.sv
design/kb_scan_decoder.sv
design/kb_host_port.sv
design/caddr_io_top.sv
testbench/tb_caddr_io_top.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the keyboard corner testbench with Verilator.
# The result is decided from sim.log; a failing run returns status 1.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_caddr_io_top -f all.f -o sim_tb > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

! grep -q "STATUS: FAIL" sim.log && grep -q "STATUS: PASS" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
